// File: common/ssf_cfg.svh
`ifndef SSF_CFG_SVH
`define SSF_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot bank size and release pacing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SSF_SLOT_COUNT 70
`define SSF_DWELL_CYCLES 440 // Cycles between two releases.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot output fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SSF_SAMPLE_WIDTH 32
`define SSF_CODE_WIDTH 2

// Only this code makes a slot eligible.
`define SSF_CODE_ACTIVE 1

`endif

// File: common/ssf_pkg.sv
`include "ssf_cfg.svh"

package ssf_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scalar types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [`SSF_SAMPLE_WIDTH-1:0] sample_t;
	typedef logic [`SSF_CODE_WIDTH-1:0] code_t;

	// One spare value so a single slot or a single cycle still gets a bit.
	typedef logic [$clog2(`SSF_SLOT_COUNT + 1)-1:0] slot_idx_t;
	typedef logic [$clog2(`SSF_DWELL_CYCLES + 1)-1:0] dwell_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bundles.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Outputs of one slot core.
	typedef struct packed {
		code_t req_code;
		code_t out_code;
		sample_t data;
	} slot_port_t;

	// Hub result after selection.
	typedef struct packed {
		code_t req_code;
		code_t out_code;
		sample_t data;
	} hub_out_t;

	// Release sequencer.
	typedef enum logic [0:0] {
		SEQ_RUN,
		SEQ_DONE
	} seq_state_t;

endpackage

// File: design/reset_stagger.sv
`timescale 1ns/100ps
`include "ssf_cfg.svh"

module reset_stagger
	import ssf_pkg::*;
(
	input logic clk,
	input logic rst,
	output logic [`SSF_SLOT_COUNT-1:0] slot_rst
);

	localparam slot_idx_t last_slot = slot_idx_t'(`SSF_SLOT_COUNT - 1);
	localparam dwell_t last_tick = dwell_t'(`SSF_DWELL_CYCLES - 1);

	seq_state_t state;
	seq_state_t state_next;
	slot_idx_t idx;
	slot_idx_t idx_next;
	dwell_t dwell;
	dwell_t dwell_next;
	logic dwell_end;
	logic final_slot;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer next state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign dwell_end = (dwell == last_tick); // Slot has had its full dwell.
	assign final_slot = (idx == last_slot);

	always_comb begin
		state_next = state;
		idx_next = idx;
		dwell_next = dwell;
		case (state)
			SEQ_RUN: begin
				if (dwell_end) begin
					dwell_next = '0;
					if (final_slot) begin
						state_next = SEQ_DONE; // Whole bank is out of reset.
					end else begin
						idx_next = idx + 1'b1;
					end
				end else begin
					dwell_next = dwell + 1'b1;
				end
			end
			SEQ_DONE: begin
				// Halted until the next global reset.
				state_next = SEQ_DONE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEQ_RUN;
			idx <= '0;
			dwell <= '0;
		end else begin
			state <= state_next;
			idx <= idx_next;
			dwell <= dwell_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-slot reset bits.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Current slot is released on the first edge it is selected.
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_rst <= '1;
		end else if (state == SEQ_RUN) begin
			slot_rst[idx] <= 1'b0;
		end
	end

endmodule

// File: design/slot_select.sv
`timescale 1ns/100ps
`include "ssf_cfg.svh"

module slot_select
	import ssf_pkg::*;
(
	input slot_port_t slots [`SSF_SLOT_COUNT],
	output hub_out_t result
);

	localparam code_t active_code = code_t'(`SSF_CODE_ACTIVE);

	logic [`SSF_SLOT_COUNT-1:0] req_match;
	logic [`SSF_SLOT_COUNT-1:0] out_match;
	logic req_hit;
	logic out_hit;
	slot_idx_t req_idx;
	slot_idx_t out_idx;

	// Lowest set bit of a match vector.
	function automatic slot_idx_t first_set(input logic [`SSF_SLOT_COUNT-1:0] match);
		slot_idx_t pick;
		pick = '0;
		// Walk downward so the lowest match is written last.
		for (int i = `SSF_SLOT_COUNT - 1; i >= 0; i--) begin
			if (match[i]) begin
				pick = slot_idx_t'(i);
			end
		end
		return pick;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Eligibility per slot.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int i = 0; i < `SSF_SLOT_COUNT; i++) begin
			req_match[i] = (slots[i].req_code == active_code);
			out_match[i] = (slots[i].out_code == active_code); // Codes 2, 3 never win.
		end
	end

	assign req_hit = |req_match;
	assign out_hit = |out_match;
	assign req_idx = first_set(req_match);
	assign out_idx = first_set(out_match);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result assembly.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The two scans pick independently. Data follows the output winner.
	always_comb begin
		result = '0;
		if (req_hit) begin
			result.req_code = slots[req_idx].req_code;
		end
		if (out_hit) begin
			result.out_code = slots[out_idx].out_code;
			result.data = slots[out_idx].data;
		end
	end

endmodule

// File: design/ssf_hub.sv
`timescale 1ns/100ps
`include "ssf_cfg.svh"

module ssf_hub
	import ssf_pkg::*;
(
	input logic clk,
	input logic rst,
	input slot_port_t slots [`SSF_SLOT_COUNT],
	output logic [`SSF_SLOT_COUNT-1:0] slot_rst,
	output hub_out_t result
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Release sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	reset_stagger u_stagger (
		.clk(clk),
		.rst(rst),
		.slot_rst(slot_rst)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Priority selection, zero latency.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	slot_select u_select (
		.slots(slots),
		.result(result)
	);

endmodule

// File: tests/ssf_hub_properties.sv
`timescale 1ns/100ps
`include "ssf_cfg.svh"

module ssf_hub_properties
	import ssf_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [`SSF_SLOT_COUNT-1:0] slot_rst,
	input hub_out_t result
);

	localparam code_t active_code = code_t'(`SSF_CODE_ACTIVE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Release sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Once low, a slot reset only rises again through rst.
	released_stays_low: assert property (
		@(posedge clk) disable iff (rst)
		!$past(rst) |-> ((~$past(slot_rst) & slot_rst) == '0)
	) else $error("A released slot reset went high again while rst was low.");

	// Bank is always a run of released slots from slot 0 up.
	release_order: assert property (
		@(posedge clk) disable iff (rst)
		(~slot_rst[`SSF_SLOT_COUNT-1:1] & slot_rst[`SSF_SLOT_COUNT-2:0]) == '0
	) else $error("A slot was released before the slot below it.");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Selection result.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	req_code_legal: assert property (
		@(posedge clk)
		(result.req_code == '0) || (result.req_code == active_code)
	) else $error("Result request code is neither zero nor the active code.");

	out_code_legal: assert property (
		@(posedge clk)
		(result.out_code == '0) || (result.out_code == active_code)
	) else $error("Result output code is neither zero nor the active code.");

endmodule

// File: tests/ssf_hub_tb.sv
`timescale 1ns/100ps
`include "ssf_cfg.svh"

module ssf_hub_tb
	import ssf_pkg::*;
();

	localparam int clk_period = 10;
	localparam int slot_count = `SSF_SLOT_COUNT;
	localparam int dwell_cycles = `SSF_DWELL_CYCLES;
	localparam int reset_cycles = 16;
	localparam int random_cycles = 2000;
	localparam int sequence_edges = slot_count * dwell_cycles;
	localparam code_t active_code = code_t'(`SSF_CODE_ACTIVE);
	localparam code_t no_code = code_t'(0);

	// Two full sequences, one partial, resets and the random run.
	localparam int watchdog_cycles = 2 * (sequence_edges + dwell_cycles)
		+ 3 * reset_cycles + random_cycles + 3 * dwell_cycles + 1000;

	logic clk;
	logic rst;
	slot_port_t slots [slot_count]; // Stands in for the slot cores.
	logic [slot_count-1:0] slot_rst;
	hub_out_t result;
	int seed;

	ssf_hub UUT (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.slot_rst(slot_rst),
		.result(result)
	);

	bind ssf_hub ssf_hub_properties u_props (
		.clk(clk),
		.rst(rst),
		.slot_rst(slot_rst),
		.result(result)
	);

	always #(clk_period / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting and compares.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic compare_code(input code_t got, input code_t exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_rst(input logic [slot_count-1:0] got,
		input logic [slot_count-1:0] exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_fields(input code_t req, input code_t out, input sample_t data,
		input string what);
		compare_code(result.req_code, req, {what, ", req_code"});
		compare_code(result.out_code, out, {what, ", out_code"});
		compare_sample(result.data, data, {what, ", data"});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference models.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bit k is high until edge k * dwell.
	function automatic logic [slot_count-1:0] expected_rst(input int edge_num);
		logic [slot_count-1:0] v;
		for (int k = 0; k < slot_count; k++) begin
			v[k] = (edge_num < k * dwell_cycles);
		end
		return v;
	endfunction

	// First active code from slot 0 upward, for each scan on its own.
	function automatic hub_out_t reference_scan();
		hub_out_t r;
		bit req_found;
		bit out_found;
		r = '0;
		req_found = 1'b0;
		out_found = 1'b0;
		for (int i = 0; i < slot_count; i++) begin
			if (!req_found && slots[i].req_code == active_code) begin
				r.req_code = active_code;
				req_found = 1'b1;
			end
			if (!out_found && slots[i].out_code == active_code) begin
				r.out_code = active_code;
				r.data = slots[i].data;
				out_found = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic check_result(input string what);
		hub_out_t exp;
		exp = reference_scan();
		check_fields(exp.req_code, exp.out_code, exp.data, what);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic step();
		@(posedge clk);
		#1; // Drive and sample just after the edge.
	endtask

	task automatic clear_slots();
		for (int i = 0; i < slot_count; i++) begin
			slots[i] = '0;
		end
	endtask

	function automatic sample_t slot_data(input int i);
		return sample_t'(i * 1000 - 35000); // Distinct, some negative.
	endfunction

	task automatic load_data();
		for (int i = 0; i < slot_count; i++) begin
			slots[i].data = slot_data(i);
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (reset_cycles) begin
			step();
			compare_rst(slot_rst, '1, "slot_rst during reset");
			check_result("result during reset");
		end
		rst = 1'b0;
	endtask

	// Edge 0 is the first edge with rst low.
	task automatic check_release(input int edges);
		for (int n = 0; n < edges; n++) begin
			step();
			compare_rst(slot_rst, expected_rst(n), $sformatf("slot_rst at edge %0d", n));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_state();
		clear_slots();
		apply_reset();
		check_fields(no_code, no_code, '0, "idle result after reset");
	endtask

	// Last release plus one more dwell of all zeros.
	task automatic test_stagger();
		check_release(sequence_edges + 1);
	endtask

	task automatic test_request_priority();
		step();
		clear_slots();
		slots[0].req_code = code_t'(2);
		slots[1].req_code = code_t'(3);
		slots[5].req_code = code_t'(1);
		slots[9].req_code = code_t'(1);
		#2;
		check_fields(active_code, no_code, '0, "req past codes 2 and 3");

		step();
		clear_slots();
		slots[0].req_code = code_t'(2);
		slots[1].req_code = code_t'(3);
		slots[2].req_code = code_t'(2);
		slots[3].req_code = code_t'(3);
		slots[40].req_code = code_t'(2);
		#2;
		check_fields(no_code, no_code, '0, "req with no active code");

		step();
		clear_slots();
		slots[68].req_code = code_t'(3);
		slots[slot_count-1].req_code = code_t'(1);
		#2;
		check_fields(active_code, no_code, '0, "req from last slot");

		step();
		clear_slots();
		#2;
		check_fields(no_code, no_code, '0, "req with all codes zero");
	endtask

	task automatic test_output_priority();
		step();
		clear_slots();
		load_data();
		slots[3].out_code = code_t'(2);
		slots[7].out_code = code_t'(1);
		slots[12].out_code = code_t'(1);
		slots[20].req_code = code_t'(1);
		#2;
		check_fields(active_code, active_code, sample_t'(-28000), "out from slot 7");

		step();
		clear_slots();
		load_data();
		slots[2].req_code = code_t'(1);
		slots[0].out_code = code_t'(3);
		slots[50].out_code = code_t'(1);
		#2;
		check_fields(active_code, active_code, sample_t'(15000), "out from slot 50");

		step();
		clear_slots();
		load_data();
		slots[0].req_code = code_t'(1);
		slots[1].out_code = code_t'(3);
		slots[30].out_code = code_t'(2);
		#2;
		check_fields(active_code, no_code, '0, "out with no active code");

		step();
		clear_slots();
		load_data();
		slots[0].req_code = code_t'(2);
		slots[10].req_code = code_t'(3);
		slots[slot_count-1].out_code = code_t'(1);
		#2;
		check_fields(no_code, active_code, sample_t'(34000), "out from last slot");

		step();
		clear_slots();
		load_data();
		slots[0].out_code = code_t'(1);
		#2;
		check_fields(no_code, active_code, sample_t'(-35000), "out from slot 0");
	endtask

	// Sparse codes so some cycles have no winner.
	task automatic test_random_mix();
		int density;
		for (int c = 0; c < random_cycles; c++) begin
			step();
			density = $random(seed) & 15;
			for (int i = 0; i < slot_count; i++) begin
				slots[i].data = sample_t'($random(seed));
				if (($random(seed) & 63) < density) begin
					slots[i].req_code = code_t'($random(seed));
				end else begin
					slots[i].req_code = no_code;
				end
				if (($random(seed) & 63) < density) begin
					slots[i].out_code = code_t'($random(seed));
				end else begin
					slots[i].out_code = no_code;
				end
			end
			#2;
			check_result($sformatf("random cycle %0d", c));
		end
	endtask

	// After DONE, then mid-run.
	task automatic test_rereset();
		clear_slots();
		apply_reset();
		check_release(3 * dwell_cycles + 1);
		apply_reset();
		check_release(sequence_edges + 1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence and watchdog.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		seed = 32'h520a2b2e;
		clear_slots();

		test_reset_state();
		test_stagger();
		test_request_priority();
		test_output_priority();
		test_random_mix();
		test_rereset();

		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		report_failure("Watchdog timeout, the tests did not finish in time.");
	end

endmodule

// File: all.f
+incdir+common
common/ssf_pkg.sv
design/reset_stagger.sv
design/slot_select.sv
design/ssf_hub.sv
tests/ssf_hub_properties.sv
tests/ssf_hub_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the hub testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f all.f \
	--top-module ssf_hub_tb \
	-o ssf_hub_sim

# A $fatal exit is not an error here, the search below decides.
sim_output=$(./obj_dir/ssf_hub_sim 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "ALL TESTS PASSED"; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed."
	exit 1
fi
